/* sim.f */
dbg_pkg.sv
dbg_mem_if.sv
uart_rx.sv
uart_tx.sv
dbg_cmd_engine.sv
dbg_ram.sv
dbg_top.sv
tb_dbg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_top -f sim.f -o tb_dbg_top \
    && ./obj_dir/tb_dbg_top | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_dbg_top.sv */
`timescale 1ns/1ps

module tb_dbg_top;

    localparam int CLKS_PER_BIT  = 8;
    localparam int MEM_ADDR_W    = 10;
    localparam int MEM_SIZE      = 2 ** MEM_ADDR_W;
    localparam int CLK_PERIOD_NS = 100;
    localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
    // single bytes and echoes, seven memory headers, then data and filler
    localparam int TOTAL_FRAMES  = 12 + 7 * (1 + dbg_pkg::HDR_BYTES) + 45;
    localparam int WATCHDOG_NS   = TOTAL_FRAMES * FRAME_CLKS * CLK_PERIOD_NS * 2;

    logic          i_clk = 1'b0;
    logic          i_reset_n;
    logic          i_rx;
    logic          o_tx;
    dbg_pkg::cmd_e o_cmd;
    logic [15:0]   o_bytes_remaining;

    logic [15:0] lfsr_state;
    logic [7:0]  mem_model [MEM_SIZE];    // scoreboard copy of the RAM
    logic [7:0]  stream_q [$];            // host bytes still to send
    logic [7:0]  reply_q [$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          tx_low_samples = 0;

    dbg_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .MEM_ADDR_W   (MEM_ADDR_W)
    ) i_dut (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_rx              (i_rx),
        .o_tx              (o_tx),
        .o_cmd             (o_cmd),
        .o_bytes_remaining (o_bytes_remaining)
    );

    always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

    // any cycle away from idle counts
    always @(negedge i_clk) begin
        if (o_tx !== 1'b1) begin
            tx_low_samples <= tx_low_samples + 1;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // taps 16 14 13 11
    endfunction

    task automatic rand_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_cmd(input dbg_pkg::cmd_e got, input dbg_pkg::cmd_e exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // o_tx has to stay idle for a frame and a bit
    task automatic expect_idle(input int since, input string what);
        repeat (FRAME_CLKS + 2 * CLKS_PER_BIT) @(negedge i_clk);
        if (tx_low_samples != since) begin
            other_errors++;
            $display("unexpected traffic on o_tx after %s at time %0t", what, $time);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(negedge i_clk);
        i_rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        for (int i = 0; i < 8; i++) begin
            i_rx = value[i];    // lsb first
            repeat (CLKS_PER_BIT) @(negedge i_clk);
        end
        i_rx = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge i_clk);     // stop bit plus one idle bit
    endtask

    task automatic send_stream();
        while (stream_q.size() > 0) begin
            send_byte(stream_q.pop_front());
        end
    endtask

    task automatic recv_byte(output logic [7:0] value, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (o_tx !== 1'b0 && waited < 10 * FRAME_CLKS) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_tx !== 1'b0) begin
            return;
        end
        repeat (CLKS_PER_BIT / 2) @(negedge i_clk);     // middle of the start bit
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            value[i] = o_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        ok = (o_tx === 1'b1);
    endtask

    task automatic collect_replies(input int count);
        logic [7:0] value;
        bit         ok;
        for (int i = 0; i < count; i++) begin
            recv_byte(value, ok);
            if (!ok) begin
                other_errors++;
                $display("reply %0d of %0d never arrived or had no stop bit, time %0t",
                         i + 1, count, $time);
                break;
            end
            reply_q.push_back(value);
        end
    endtask

    task automatic exchange(input int replies);
        reply_q.delete();
        fork
            send_stream();
            collect_replies(replies);
        join
    endtask

    task automatic queue_mem_header(input dbg_pkg::cmd_e cmd, input logic [15:0] addr,
                                    input logic [15:0] count);
        stream_q.push_back(cmd);
        stream_q.push_back(addr[15:8]);     // big-endian
        stream_q.push_back(addr[7:0]);
        stream_q.push_back(count[15:8]);
        stream_q.push_back(count[7:0]);
    endtask

    // compare replies with the scoreboard that wraps at MEM_SIZE
    task automatic check_reads(input logic [15:0] start, input string what);
        for (int i = 0; i < reply_q.size(); i++) begin
            check_byte(reply_q[i], mem_model[(int'(start) + i) % MEM_SIZE],
                       $sformatf("%s byte %0d", what, i));
        end
        expect_idle(tx_low_samples, what);
    endtask

    task automatic reset_and_nop();
        check_cmd(o_cmd, dbg_pkg::CMD_NOP, "o_cmd after reset");
        check_count(o_bytes_remaining, 16'd0, "count after reset");
        send_byte(8'h00);
        check_count(o_bytes_remaining, 16'd0, "count after NOP");
        send_byte(8'h7F);
        check_cmd(o_cmd, dbg_pkg::CMD_NOP, "o_cmd after opcode 0x7F");
        check_count(o_bytes_remaining, 16'd0, "count after opcode 0x7F");
        expect_idle(0, "reset, NOP and unknown opcode");
    endtask

    task automatic echo_values();
        logic [7:0] values [4];
        for (int i = 0; i < 4; i++) begin
            rand_byte(values[i]);
            stream_q.push_back(dbg_pkg::CMD_ECHO);
            stream_q.push_back(values[i]);
        end
        exchange(4);
        for (int i = 0; i < reply_q.size(); i++) begin
            check_byte(reply_q[i], values[i], $sformatf("echo reply %0d", i));
        end
        expect_idle(tx_low_samples, "ECHO");
    endtask

    task automatic write_block(input logic [15:0] addr, input int count);
        logic [7:0] value;
        int         low_before;
        queue_mem_header(dbg_pkg::CMD_MEM_WRITE, addr, 16'(count));
        for (int i = 0; i < count; i++) begin
            rand_byte(value);
            stream_q.push_back(value);
            mem_model[(int'(addr) + i) % MEM_SIZE] = value;
        end
        low_before = tx_low_samples;
        exchange(0);
        expect_idle(low_before, "MEM_WRITE");   // writes never answer
    endtask

    task automatic read_block(input logic [15:0] addr, input int count, input string what);
        queue_mem_header(dbg_pkg::CMD_MEM_READ, addr, 16'(count));
        repeat (count) stream_q.push_back(8'hA5);   // filler
        exchange(count);
        check_reads(addr, what);
    endtask

    task automatic read_count_tracking();
        reply_q.delete();
        queue_mem_header(dbg_pkg::CMD_MEM_READ, 16'h0100, 16'd5);
        fork
            begin
                send_stream();
                check_count(o_bytes_remaining, 16'd5, "count after MEM_READ header");
                for (int i = 4; i >= 0; i--) begin
                    send_byte(8'h5A);
                    check_count(o_bytes_remaining, 16'(i), "count during MEM_READ");
                    check_cmd(o_cmd, (i > 0) ? dbg_pkg::CMD_MEM_READ : dbg_pkg::CMD_NOP,
                              "o_cmd during MEM_READ");
                end
            end
            collect_replies(5);
        join
        check_reads(16'h0100, "counted read");
    endtask

    task automatic zero_count_command();
        logic [7:0] value;
        queue_mem_header(dbg_pkg::CMD_MEM_WRITE, 16'h0200, 16'd0);
        exchange(0);
        check_count(o_bytes_remaining, 16'd0, "count after empty MEM_WRITE");
        check_cmd(o_cmd, dbg_pkg::CMD_NOP, "o_cmd after empty MEM_WRITE");
        rand_byte(value);
        stream_q.push_back(dbg_pkg::CMD_ECHO);
        stream_q.push_back(value);
        exchange(1);
        if (reply_q.size() > 0) begin
            check_byte(reply_q[0], value, "echo after empty MEM_WRITE");
        end
    endtask

    initial begin
        i_reset_n = 1'b0;
        i_rx = 1'b1;
        lfsr_state = 16'd5971;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;

        reset_and_nop();
        echo_values();
        write_block(16'h0100, 16);
        read_block(16'h0100, 16, "readback 0x0100");
        read_count_tracking();
        write_block(16'h03FE, 4);       // last two bytes land at 0 and 1
        read_block(16'h0000, 2, "wrapped read 0x0000");
        read_block(16'h0400, 2, "wrapped read 0x0400");
        zero_count_command();

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* dbg_top.sv */
`timescale 1ns/1ps

module dbg_top #(
    parameter int CLKS_PER_BIT = 868,   // 100 MHz at 115200 baud
    parameter int MEM_ADDR_W   = 10
) (
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_rx,
    output logic           o_tx,
    output dbg_pkg::cmd_e  o_cmd,
    output logic [15:0]    o_bytes_remaining
);

    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       tx_valid;
    logic [7:0] tx_byte;

    dbg_mem_if mem_bus ();

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rx      (i_rx),
        .o_valid   (rx_valid),
        .o_byte    (rx_byte)
    );

    // the host paces its requests so replies never overlap
    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (tx_valid),
        .i_byte    (tx_byte),
        .o_tx      (o_tx),
        .o_busy    ()
    );

    dbg_cmd_engine u_engine (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_rx_valid        (rx_valid),
        .i_rx_byte         (rx_byte),
        .o_tx_valid        (tx_valid),
        .o_tx_byte         (tx_byte),
        .mem               (mem_bus.engine),
        .o_cmd             (o_cmd),
        .o_bytes_remaining (o_bytes_remaining)
    );

    dbg_ram #(.MEM_ADDR_W(MEM_ADDR_W)) u_ram (
        .i_clk (i_clk),
        .mem   (mem_bus.ram)
    );

endmodule

/* dbg_ram.sv */
`timescale 1ns/1ps

module dbg_ram #(
    parameter int MEM_ADDR_W = 10
) (
    input  logic    i_clk,
    dbg_mem_if.ram  mem
);

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    logic [7:0] r_mem [DEPTH];
    logic [7:0] r_rdata;

    // upper address bits are ignored, so accesses wrap
    wire [MEM_ADDR_W-1:0] w_addr = mem.mem_addr[MEM_ADDR_W-1:0];

    always_ff @(posedge i_clk) begin
        if (mem.mem_en) begin
            if (mem.mem_op == dbg_pkg::MEM_WRITE) begin
                r_mem[w_addr] <= mem.mem_wdata;
            end else begin
                r_rdata <= r_mem[w_addr];   // held until the next read
            end
        end
    end

    assign mem.mem_rdata = r_rdata;

endmodule

/* dbg_cmd_engine.sv */
`timescale 1ns/1ps

module dbg_cmd_engine (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_rx_valid,
    input  logic [7:0]          i_rx_byte,
    output logic                o_tx_valid,
    output logic [7:0]          o_tx_byte,
    dbg_mem_if.engine           mem,
    output dbg_pkg::cmd_e       o_cmd,
    output logic [15:0]         o_bytes_remaining
);

    localparam logic [2:0] HDR_END = 3'(dbg_pkg::HDR_BYTES);

    dbg_pkg::cmd_e    r_cmd;
    logic [15:0]      r_remaining;
    logic [2:0]       r_index;      // saturates once the header is done
    logic [15:0]      r_addr;
    logic             r_mem_en;
    dbg_pkg::mem_op_e r_mem_op;
    logic [7:0]       r_wdata;
    logic             r_echo_valid;
    logic             r_rd_pend;    // read data is on mem_rdata this cycle
    logic [7:0]       r_tx_byte;

    wire w_body   = i_rx_valid && (r_remaining != 16'd0);
    wire w_is_mem = (r_cmd == dbg_pkg::CMD_MEM_WRITE) || (r_cmd == dbg_pkg::CMD_MEM_READ);
    wire w_in_hdr = (r_index != HDR_END);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_cmd        <= dbg_pkg::CMD_NOP;
            r_remaining  <= '0;
            r_index      <= '0;
            r_addr       <= '0;
            r_mem_en     <= 1'b0;
            r_mem_op     <= dbg_pkg::MEM_READ;
            r_echo_valid <= 1'b0;
            r_rd_pend    <= 1'b0;
        end else begin
            r_mem_en     <= 1'b0;
            r_echo_valid <= 1'b0;
            r_rd_pend    <= r_mem_en && (r_mem_op == dbg_pkg::MEM_READ);

            if (r_mem_en) begin
                r_addr <= r_addr + 16'd1;   // step after each access
            end

            if (i_rx_valid && r_remaining == 16'd0) begin
                // opcode byte
                r_index <= '0;
                case (i_rx_byte)
                    dbg_pkg::CMD_ECHO: begin
                        r_cmd       <= dbg_pkg::CMD_ECHO;
                        r_remaining <= 16'd1;
                    end
                    dbg_pkg::CMD_MEM_WRITE, dbg_pkg::CMD_MEM_READ: begin
                        r_cmd       <= dbg_pkg::cmd_e'(i_rx_byte);
                        r_remaining <= 16'(dbg_pkg::HDR_BYTES);     // count added later
                    end
                    default: begin
                        r_cmd       <= dbg_pkg::CMD_NOP;   // unknown opcodes too
                        r_remaining <= '0;
                    end
                endcase
            end else if (w_body) begin
                r_remaining <= r_remaining - 16'd1;
                if (w_in_hdr) begin
                    r_index <= r_index + 1'b1;
                end
                if (r_cmd == dbg_pkg::CMD_ECHO) begin
                    r_echo_valid <= 1'b1;
                end else if (w_is_mem && w_in_hdr) begin
                    case (int'(r_index))
                        dbg_pkg::HDR_ADDR_HI:  r_addr[15:8] <= i_rx_byte;
                        dbg_pkg::HDR_ADDR_LO:  r_addr[7:0]  <= i_rx_byte;
                        dbg_pkg::HDR_COUNT_HI:
                            r_remaining <= r_remaining - 16'd1 + {i_rx_byte, 8'h00};
                        default:
                            r_remaining <= r_remaining - 16'd1 + {8'h00, i_rx_byte};
                    endcase
                end else if (w_is_mem) begin
                    // data byte for a write, filler byte for a read
                    r_mem_en <= 1'b1;
                    r_mem_op <= (r_cmd == dbg_pkg::CMD_MEM_WRITE) ? dbg_pkg::MEM_WRITE
                                                                  : dbg_pkg::MEM_READ;
                end
            end else if (!i_rx_valid && r_remaining == 16'd0) begin
                r_cmd <= dbg_pkg::CMD_NOP;  // command finished
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_body && r_cmd == dbg_pkg::CMD_ECHO) begin
            r_tx_byte <= i_rx_byte;
        end else if (r_rd_pend) begin
            r_tx_byte <= mem.mem_rdata;     // keep the last reply byte
        end
        if (w_body && r_cmd == dbg_pkg::CMD_MEM_WRITE && !w_in_hdr) begin
            r_wdata <= i_rx_byte;
        end
    end

    // read reply goes straight from the RAM output register
    assign o_tx_valid = r_echo_valid || r_rd_pend;
    assign o_tx_byte  = r_rd_pend ? mem.mem_rdata : r_tx_byte;

    assign mem.mem_addr  = r_addr;
    assign mem.mem_op    = r_mem_op;
    assign mem.mem_en    = r_mem_en;
    assign mem.mem_wdata = r_wdata;

    assign o_cmd             = r_cmd;
    assign o_bytes_remaining = r_remaining;

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_valid,
    input  logic [7:0] i_byte,
    output logic       o_tx,
    output logic       o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [9:0]       r_shift;    // stop, data[7:0], start
    logic [CNT_W-1:0] r_cnt;
    logic [3:0]       r_bits;     // bits already sent
    logic             r_busy;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_shift <= '1;      // line idles high
            r_cnt   <= '0;
            r_bits  <= '0;
            r_busy  <= 1'b0;
        end else if (!r_busy) begin
            if (i_valid) begin
                r_shift <= {1'b1, i_byte, 1'b0};
                r_cnt   <= '0;
                r_bits  <= '0;
                r_busy  <= 1'b1;
            end
        end else if (r_cnt == LAST) begin
            r_cnt <= '0;
            // ones fill in behind, so the line ends up idle
            r_shift <= {1'b1, r_shift[9:1]};
            if (r_bits == 4'd9) begin
                r_busy <= 1'b0;
            end else begin
                r_bits <= r_bits + 1'b1;
            end
        end else begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    assign o_tx   = r_shift[0];
    assign o_busy = r_busy;

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_rx,
    output logic       o_valid,
    output logic [7:0] o_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        r_state;
    logic [1:0]       r_sync;     // two flops against metastability
    logic [CNT_W-1:0] r_cnt;      // clocks within the current bit
    logic [2:0]       r_bit;
    logic             r_valid;
    logic [7:0]       r_shift;

    wire w_line    = r_sync[1];
    wire w_bit_end = (r_cnt == LAST);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_sync  <= 2'b11;
            r_state <= RX_IDLE;
            r_cnt   <= '0;
            r_bit   <= '0;
            r_valid <= 1'b0;
        end else begin
            r_sync  <= {r_sync[0], i_rx};
            r_valid <= 1'b0;
            r_cnt   <= r_cnt + 1'b1;
            case (r_state)
                RX_IDLE: begin
                    r_cnt <= '0;
                    r_bit <= '0;
                    if (!w_line) begin
                        r_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (r_cnt == HALF) begin
                        r_cnt   <= '0;
                        r_state <= w_line ? RX_IDLE : RX_DATA;  // high again means a glitch
                    end
                end
                RX_DATA: begin
                    if (w_bit_end) begin
                        r_cnt <= '0;
                        r_bit <= r_bit + 1'b1;
                        if (r_bit == 3'd7) begin
                            r_state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (w_bit_end) begin    // middle of the stop bit
                        r_valid <= 1'b1;
                        r_state <= RX_IDLE;
                    end
                end
                default: r_state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first and ends up in bit 0
    always_ff @(posedge i_clk) begin
        if (r_state == RX_DATA && w_bit_end) begin
            r_shift <= {w_line, r_shift[7:1]};
        end
    end

    assign o_valid = r_valid;
    assign o_byte  = r_shift;

endmodule

/* dbg_mem_if.sv */
`timescale 1ns/1ps

// byte-wide memory bus between the command engine and the RAM
interface dbg_mem_if;

    logic [15:0]          mem_addr;     // full 16-bit debug address
    dbg_pkg::mem_op_e     mem_op;
    logic                 mem_en;       // one access per high cycle
    logic [7:0]           mem_wdata;
    logic [7:0]           mem_rdata;    // valid the cycle after a read

    modport engine (
        output mem_addr,
        output mem_op,
        output mem_en,
        output mem_wdata,
        input  mem_rdata
    );

    modport ram (
        input  mem_addr,
        input  mem_op,
        input  mem_en,
        input  mem_wdata,
        output mem_rdata
    );

endinterface

/* dbg_pkg.sv */
package dbg_pkg;

    // opcode byte at the start of each command
    typedef enum logic [7:0] {
        CMD_NOP       = 8'd0,   // 1 byte
        CMD_ECHO      = 8'd1,   // opcode, value; value goes back
        CMD_MEM_WRITE = 8'd2,   // opcode, header, count data bytes
        CMD_MEM_READ  = 8'd3    // opcode, header, count filler bytes
    } cmd_e;

    // kind of access on the memory bus
    typedef enum logic {
        MEM_WRITE = 1'b0,
        MEM_READ  = 1'b1
    } mem_op_e;

    // big-endian memory command header after the opcode
    //   address hi, address lo, count hi, count lo
    parameter int HDR_BYTES = 4;

    // byte positions inside the header
    parameter int HDR_ADDR_HI  = 0;
    parameter int HDR_ADDR_LO  = 1;
    parameter int HDR_COUNT_HI = 2;
    parameter int HDR_COUNT_LO = 3;

endpackage
